// ==== hdl/periph_defines.svh ====
// ------------------------------------------------------------
// Widths, region map and register offsets of the subsystem.
// Regions are selected by address bits 11:8, 256 bytes each.
// All registers are full 32-bit words; byte strobes unused.
// ------------------------------------------------------------
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

`define PERIPH_ADDR_W   12
`define PERIPH_DATA_W   32

// Region codes in address bits 11:8
`define REGION_IRQ      4'h0
`define REGION_TIMER    4'h1
`define REGION_GPIO     4'h2

`define NUM_TIMERS      2
`define NUM_TARGETS     2
`define NUM_LEDS        8

`define IRQ_PENDING_OFF 8'h00
`define IRQ_EN0_OFF     8'h04
`define IRQ_EN1_OFF     8'h08

// Per channel, channel n starts at n * TIMER_STRIDE
`define TIMER_CTRL_OFF  8'h00
`define TIMER_COUNT_OFF 8'h04
`define TIMER_CMP_OFF   8'h08
`define TIMER_STRIDE    8'h10

`define GPIO_LED_OFF    8'h00
`define GPIO_DIP_OFF    8'h04

`define RESP_OKAY       2'b00
`define RESP_SLVERR     2'b10

`endif

// ==== hdl/periph_pkg.sv ====
// ------------------------------------------------------------
// Shared types of the peripheral subsystem.
// Widths follow the constants of the defines header.
// ------------------------------------------------------------
package periph_pkg;

    typedef logic [11:0] addr_t;
    typedef logic [7:0]  reg_off_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0]  axi_resp_t;

    // One source per timer channel, one output per target
    typedef logic [1:0]  irq_src_t;
    typedef logic [1:0]  irq_tgt_t;

    typedef logic [7:0]  led_t;

    typedef enum logic [1:0] {
        IDLE,
        WRESP,
        RRESP
    } bridge_state_e;

endpackage

// ==== hdl/axi_lite_reg_bridge.sv ====
// ------------------------------------------------------------
// AXI4-Lite slave to single-cycle register bus.
// One transaction at a time; a pending read beats a write.
// AW and W must be valid together to be accepted.
// Unmapped regions answer SLVERR and read as zero.
// ------------------------------------------------------------
`include "periph_defines.svh"

module axi_lite_reg_bridge import periph_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      awvalid_i,
    input  addr_t     awaddr_i,
    output logic      awready_o,
    input  logic      wvalid_i,
    input  data_t     wdata_i,
    output logic      wready_o,
    output logic      bvalid_o,
    output axi_resp_t bresp_o,
    input  logic      bready_i,
    input  logic      arvalid_i,
    input  addr_t     araddr_i,
    output logic      arready_o,
    output logic      rvalid_o,
    output data_t     rdata_o,
    output axi_resp_t rresp_o,
    input  logic      rready_i,
    output reg_off_t  reg_off_o,
    output data_t     reg_wdata_o,
    output logic      reg_write_o,
    output logic      irq_sel_o,
    output logic      timer_sel_o,
    output logic      gpio_sel_o,
    input  data_t     irq_rdata_i,
    input  data_t     timer_rdata_i,
    input  data_t     gpio_rdata_i
);

    bridge_state_e state_q;
    logic          rd_hs;
    logic          wr_hs;
    logic          access;
    addr_t         acc_addr;
    logic [3:0]    region;
    logic          region_ok;
    data_t         rd_word;
    axi_resp_t     resp_q;
    data_t         rdata_q;

    // ------------------------------------------------------------
    // Handshakes, only accepted in IDLE
    // ------------------------------------------------------------
    assign arready_o = (state_q == IDLE) && arvalid_i;
    assign awready_o = (state_q == IDLE) && awvalid_i && wvalid_i && !arvalid_i;
    assign wready_o  = awready_o;

    assign rd_hs  = arready_o;
    assign wr_hs  = awready_o;
    assign access = rd_hs || wr_hs;

    assign acc_addr = rd_hs ? araddr_i : awaddr_i;
    assign region   = acc_addr[`PERIPH_ADDR_W-1 -: 4];

    // ------------------------------------------------------------
    // Region decode and read mux
    // ------------------------------------------------------------
    always_comb begin
        irq_sel_o   = 1'b0;
        timer_sel_o = 1'b0;
        gpio_sel_o  = 1'b0;
        region_ok   = 1'b1;
        rd_word     = '0;
        case (region)
            `REGION_IRQ: begin
                irq_sel_o = access;
                rd_word   = irq_rdata_i;
            end
            `REGION_TIMER: begin
                timer_sel_o = access;
                rd_word     = timer_rdata_i;
            end
            `REGION_GPIO: begin
                gpio_sel_o = access;
                rd_word    = gpio_rdata_i;
            end
            default: region_ok = 1'b0;
        endcase
    end

    assign reg_off_o   = reg_off_t'(acc_addr);
    assign reg_wdata_o = wdata_i;
    assign reg_write_o = wr_hs;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (rd_hs) begin
                        state_q <= RRESP;
                    end else if (wr_hs) begin
                        state_q <= WRESP;
                    end
                end
                WRESP: begin
                    if (bready_i) begin
                        state_q <= IDLE;
                    end
                end
                RRESP: begin
                    if (rready_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Response held for the whole response phase
    always_ff @(posedge clk_i) begin
        if (access) begin
            resp_q  <= region_ok ? `RESP_OKAY : `RESP_SLVERR;
            rdata_q <= rd_word;
        end
    end

    assign bvalid_o = (state_q == WRESP);
    assign rvalid_o = (state_q == RRESP);
    assign bresp_o  = resp_q;
    assign rresp_o  = resp_q;
    assign rdata_o  = rdata_q;

endmodule

// ==== hdl/irq_ctrl.sv ====
// ------------------------------------------------------------
// Level-sensitive interrupt controller, no priorities.
// PENDING is read-only and shows the live source levels.
// Target outputs are registered, one cycle behind inputs.
// ------------------------------------------------------------
`include "periph_defines.svh"

module irq_ctrl import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     sel_i,
    input  logic     write_i,
    input  reg_off_t off_i,
    input  data_t    wdata_i,
    output data_t    rdata_o,
    input  irq_src_t irq_src_i,
    output irq_tgt_t irq_o
);

    irq_src_t en_q [`NUM_TARGETS];
    irq_tgt_t irq_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int t = 0; t < `NUM_TARGETS; t++) begin
                en_q[t] <= '0;
            end
        end else if (sel_i && write_i) begin
            case (off_i)
                `IRQ_EN0_OFF: en_q[0] <= irq_src_t'(wdata_i);
                `IRQ_EN1_OFF: en_q[1] <= irq_src_t'(wdata_i);
                default: ;
            endcase
        end
    end

    // Any enabled pending source raises the target
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            irq_q <= '0;
        end else begin
            for (int t = 0; t < `NUM_TARGETS; t++) begin
                irq_q[t] <= |(irq_src_i & en_q[t]);
            end
        end
    end

    always_comb begin
        case (off_i)
            `IRQ_PENDING_OFF: rdata_o = data_t'(irq_src_i);
            `IRQ_EN0_OFF:     rdata_o = data_t'(en_q[0]);
            `IRQ_EN1_OFF:     rdata_o = data_t'(en_q[1]);
            default:          rdata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

endmodule

// ==== hdl/cmp_timer.sv ====
// ------------------------------------------------------------
// Free-running compare timers, no prescaler.
// CTRL bit 0 enables, bit 1 reads the sticky match flag.
// On match the counter wraps to zero and the flag is set.
// Any write to CTRL clears the flag.
// ------------------------------------------------------------
`include "periph_defines.svh"

module cmp_timer import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     sel_i,
    input  logic     write_i,
    input  reg_off_t off_i,
    input  data_t    wdata_i,
    output data_t    rdata_o,
    output irq_src_t irq_o
);

    data_t chan_rdata [`NUM_TIMERS];

    for (genvar i = 0; i < `NUM_TIMERS; i++) begin : gen_chan
        localparam reg_off_t ctrl_off  = reg_off_t'(i * `TIMER_STRIDE + `TIMER_CTRL_OFF);
        localparam reg_off_t count_off = reg_off_t'(i * `TIMER_STRIDE + `TIMER_COUNT_OFF);
        localparam reg_off_t cmp_off   = reg_off_t'(i * `TIMER_STRIDE + `TIMER_CMP_OFF);

        logic  en_q;
        logic  flag_q;
        data_t count_q;
        data_t cmp_q;
        logic  wr;

        assign wr = sel_i && write_i;

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                en_q    <= 1'b0;
                flag_q  <= 1'b0;
                count_q <= '0;
                cmp_q   <= '0;
            end else begin
                if (wr && off_i == ctrl_off) begin
                    en_q   <= wdata_i[0];
                    flag_q <= 1'b0;
                end else if (en_q && count_q == cmp_q) begin
                    flag_q <= 1'b1;
                end

                if (wr && off_i == cmp_off) begin
                    cmp_q <= wdata_i;
                end

                // Software write to COUNT beats the increment
                if (wr && off_i == count_off) begin
                    count_q <= wdata_i;
                end else if (en_q) begin
                    if (count_q == cmp_q) begin
                        count_q <= '0;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
            end
        end

        always_comb begin
            case (off_i)
                ctrl_off:  chan_rdata[i] = data_t'({flag_q, en_q});
                count_off: chan_rdata[i] = count_q;
                cmp_off:   chan_rdata[i] = cmp_q;
                default:   chan_rdata[i] = '0;
            endcase
        end

        assign irq_o[i] = flag_q;
    end

    // Offsets are disjoint, so at most one channel answers
    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < `NUM_TIMERS; i++) begin
            rdata_o = rdata_o | chan_rdata[i];
        end
    end

endmodule

// ==== hdl/gpio_regs.sv ====
// ------------------------------------------------------------
// LED output register and DIP-switch input.
// Switches pass a two-flop synchronizer before readback.
// ------------------------------------------------------------
`include "periph_defines.svh"

module gpio_regs import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     sel_i,
    input  logic     write_i,
    input  reg_off_t off_i,
    input  data_t    wdata_i,
    output data_t    rdata_o,
    input  led_t     dip_switches_i,
    output led_t     leds_o
);

    led_t leds_q;
    led_t dip_meta_q;
    led_t dip_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            leds_q <= '0;
        end else if (sel_i && write_i && off_i == `GPIO_LED_OFF) begin
            leds_q <= wdata_i[`NUM_LEDS-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        dip_meta_q <= dip_switches_i;
        dip_q      <= dip_meta_q;
    end

    always_comb begin
        case (off_i)
            `GPIO_LED_OFF: rdata_o = {{(`PERIPH_DATA_W-`NUM_LEDS){1'b0}}, leds_q};
            `GPIO_DIP_OFF: rdata_o = {{(`PERIPH_DATA_W-`NUM_LEDS){1'b0}}, dip_q};
            default:       rdata_o = '0;
        endcase
    end

    assign leds_o = leds_q;

endmodule

// ==== hdl/periph_top.sv ====
// ------------------------------------------------------------
// Peripheral subsystem behind one AXI4-Lite slave port.
// Writes are always full words, so wstrb_i is not used.
// Timer match flags drive the interrupt controller.
// ------------------------------------------------------------
`include "periph_defines.svh"

module periph_top import periph_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      awvalid_i,
    input  addr_t     awaddr_i,
    output logic      awready_o,
    input  logic      wvalid_i,
    input  data_t     wdata_i,
    input  logic [3:0] wstrb_i,
    output logic      wready_o,
    output logic      bvalid_o,
    output axi_resp_t bresp_o,
    input  logic      bready_i,
    input  logic      arvalid_i,
    input  addr_t     araddr_i,
    output logic      arready_o,
    output logic      rvalid_o,
    output data_t     rdata_o,
    output axi_resp_t rresp_o,
    input  logic      rready_i,
    output irq_tgt_t  irq_o,
    output led_t      leds_o,
    input  led_t      dip_switches_i
);

    reg_off_t reg_off;
    data_t    reg_wdata;
    logic     reg_write;
    logic     irq_sel;
    logic     timer_sel;
    logic     gpio_sel;
    data_t    irq_rdata;
    data_t    timer_rdata;
    data_t    gpio_rdata;
    irq_src_t irq_src;

    axi_lite_reg_bridge i_bridge (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .awvalid_i     ( awvalid_i   ),
        .awaddr_i      ( awaddr_i    ),
        .awready_o     ( awready_o   ),
        .wvalid_i      ( wvalid_i    ),
        .wdata_i       ( wdata_i     ),
        .wready_o      ( wready_o    ),
        .bvalid_o      ( bvalid_o    ),
        .bresp_o       ( bresp_o     ),
        .bready_i      ( bready_i    ),
        .arvalid_i     ( arvalid_i   ),
        .araddr_i      ( araddr_i    ),
        .arready_o     ( arready_o   ),
        .rvalid_o      ( rvalid_o    ),
        .rdata_o       ( rdata_o     ),
        .rresp_o       ( rresp_o     ),
        .rready_i      ( rready_i    ),
        .reg_off_o     ( reg_off     ),
        .reg_wdata_o   ( reg_wdata   ),
        .reg_write_o   ( reg_write   ),
        .irq_sel_o     ( irq_sel     ),
        .timer_sel_o   ( timer_sel   ),
        .gpio_sel_o    ( gpio_sel    ),
        .irq_rdata_i   ( irq_rdata   ),
        .timer_rdata_i ( timer_rdata ),
        .gpio_rdata_i  ( gpio_rdata  )
    );

    irq_ctrl i_irq_ctrl (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .sel_i     ( irq_sel   ),
        .write_i   ( reg_write ),
        .off_i     ( reg_off   ),
        .wdata_i   ( reg_wdata ),
        .rdata_o   ( irq_rdata ),
        .irq_src_i ( irq_src   ),
        .irq_o     ( irq_o     )
    );

    cmp_timer i_cmp_timer (
        .clk_i   ( clk_i       ),
        .rst_n_i ( rst_n_i     ),
        .sel_i   ( timer_sel   ),
        .write_i ( reg_write   ),
        .off_i   ( reg_off     ),
        .wdata_i ( reg_wdata   ),
        .rdata_o ( timer_rdata ),
        .irq_o   ( irq_src     )
    );

    gpio_regs i_gpio_regs (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .sel_i          ( gpio_sel       ),
        .write_i        ( reg_write      ),
        .off_i          ( reg_off        ),
        .wdata_i        ( reg_wdata      ),
        .rdata_o        ( gpio_rdata     ),
        .dip_switches_i ( dip_switches_i ),
        .leds_o         ( leds_o         )
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
// ------------------------------------------------------------
// Clock and reset for the testbench, 100 ns period.
// Reset is low for 5 rising edges, released 10 ns after one.
// ------------------------------------------------------------
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10 rst_n_o = 1'b1;
    end

endmodule

// ==== tb/tb_periph_top.sv ====
// ------------------------------------------------------------
// Directed test of the subsystem over AXI4-Lite.
// Inputs change 10 ns after a rising edge, outputs are
// sampled at the falling edge. One bus transfer at a time.
// ------------------------------------------------------------
`include "periph_defines.svh"

module tb_periph_top import periph_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // About 30 bus transfers of 4 to 5 cycles plus two timer runs
    localparam int MAX_CYCLES = 3000;
    localparam int MAX_POLLS  = 40;

    logic clk, rst_n;
    logic awvalid, wvalid, bready, arvalid, rready;
    addr_t awaddr, araddr;
    data_t wdata;
    logic [3:0] wstrb;
    led_t dip_switches;
    logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
    axi_resp_t bresp_o, rresp_o;
    data_t rdata_o;
    irq_tgt_t irq_o;
    led_t leds_o;

    integer seed = 32'h2b43_9635;
    string test_name = "reset";
    int cycles = 0;

    tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    periph_top DUT (
        .clk_i(clk), .rst_n_i(rst_n),
        .awvalid_i(awvalid), .awaddr_i(awaddr), .awready_o(awready_o),
        .wvalid_i(wvalid), .wdata_i(wdata), .wstrb_i(wstrb), .wready_o(wready_o),
        .bvalid_o(bvalid_o), .bresp_o(bresp_o), .bready_i(bready),
        .arvalid_i(arvalid), .araddr_i(araddr), .arready_o(arready_o),
        .rvalid_o(rvalid_o), .rdata_o(rdata_o), .rresp_o(rresp_o), .rready_i(rready),
        .irq_o(irq_o), .leds_o(leds_o), .dip_switches_i(dip_switches)
    );

    // ------------------------------------------------------------
    // Protocol and reset properties
    // ------------------------------------------------------------
    reset_values: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |=> (irq_o == '0 && leds_o == '0 && !bvalid_o && !rvalid_o))
    else begin
        $display("error %s: outputs not zero during or after reset", test_name);
        $display("TEST FAILED");
        $fatal(1);
    end

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid_o && !bready) |=> (bvalid_o && $stable(bresp_o)))
    else begin
        $display("error %s: write response dropped or changed while stalled", test_name);
        $display("TEST FAILED");
        $fatal(1);
    end

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid_o && !rready) |=> (rvalid_o && $stable(rdata_o) && $stable(rresp_o)))
    else begin
        $display("error %s: read response dropped or changed while stalled", test_name);
        $display("TEST FAILED");
        $fatal(1);
    end

    busy_no_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid_o || rvalid_o) |-> (!arready_o && !awready_o && !wready_o))
    else begin
        $display("error %s: bridge accepted a request during a response", test_name);
        $display("TEST FAILED");
        $fatal(1);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout in %s: run did not finish in %0d cycles", test_name, MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // ------------------------------------------------------------
    // Bus helpers
    // ------------------------------------------------------------
    function automatic addr_t reg_addr(input logic [3:0] region, input reg_off_t off);
        return {region, off};
    endfunction

    task automatic compare_word(input data_t exp, input data_t act);
        assert (act === exp) else begin
            $display("error %s: expected %h actual %h", test_name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input addr_t addr, input data_t data, output axi_resp_t resp);
        @(posedge clk);
        #10;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        @(negedge clk);
        while (!(awready_o && wready_o)) @(negedge clk);
        @(posedge clk);
        #10;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge clk);
        while (!bvalid_o) @(negedge clk);
        resp = bresp_o;
        @(posedge clk);
        #10;
        bready = 1'b0;
    endtask

    task automatic read_reg(input addr_t addr, output data_t data, output axi_resp_t resp);
        @(posedge clk);
        #10;
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge clk);
        while (!arready_o) @(negedge clk);
        @(posedge clk);
        #10;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid_o) @(negedge clk);
        data = rdata_o;
        resp = rresp_o;
        @(posedge clk);
        #10;
        rready = 1'b0;
    endtask

    // Polls PENDING until the given source is set
    task automatic wait_pending(input int src);
        data_t     pend;
        axi_resp_t resp;
        int        polls;
        pend  = '0;
        polls = 0;
        while (!pend[src] && polls < MAX_POLLS) begin
            read_reg(reg_addr(`REGION_IRQ, `IRQ_PENDING_OFF), pend, resp);
            polls++;
        end
        assert (pend[src]) else begin
            $display("error %s: pending bit %0d never set", test_name, src);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Compare value 20, route to one target, match, then stop the channel
    task automatic run_timer(input int ch);
        reg_off_t  base;
        data_t     rd;
        axi_resp_t resp;
        base = reg_off_t'(ch * `TIMER_STRIDE);
        write_reg(reg_addr(`REGION_TIMER, base + `TIMER_CMP_OFF), 32'd20, resp);
        write_reg(reg_addr(`REGION_IRQ, ch ? `IRQ_EN1_OFF : `IRQ_EN0_OFF),
                  data_t'(1 << ch), resp);
        write_reg(reg_addr(`REGION_TIMER, base + `TIMER_CTRL_OFF), 32'h1, resp);
        wait_pending(ch);
        @(negedge clk);
        compare_word(data_t'(1 << ch), data_t'(irq_o));
        read_reg(reg_addr(`REGION_TIMER, base + `TIMER_CTRL_OFF), rd, resp);
        compare_word(32'h3, rd);
        write_reg(reg_addr(`REGION_TIMER, base + `TIMER_CTRL_OFF), 32'h0, resp);
        // Flag cleared at the write edge, irq_o one edge later
        compare_word(32'h0, data_t'(irq_o));
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    initial begin
        data_t     led_val;
        data_t     dip_val;
        data_t     bp_val;
        data_t     rd;
        axi_resp_t resp;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        wstrb        = 4'hf;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        dip_switches = '0;

        @(posedge rst_n);
        @(negedge clk);
        compare_word(32'h0, {leds_o, irq_o, bvalid_o, rvalid_o});

        test_name = "gpio";
        led_val = data_t'(led_t'($random(seed)));
        write_reg(reg_addr(`REGION_GPIO, `GPIO_LED_OFF), led_val, resp);
        compare_word(`RESP_OKAY, resp);
        compare_word(led_val, data_t'(leds_o));
        read_reg(reg_addr(`REGION_GPIO, `GPIO_LED_OFF), rd, resp);
        compare_word(`RESP_OKAY, resp);
        compare_word(led_val, rd);
        dip_val = data_t'(led_t'($random(seed)));
        @(posedge clk);
        #10;
        dip_switches = led_t'(dip_val);
        repeat (3) @(posedge clk);
        read_reg(reg_addr(`REGION_GPIO, `GPIO_DIP_OFF), rd, resp);
        compare_word(dip_val, rd);

        test_name = "decode_error";
        write_reg(reg_addr(4'h3, 8'h00), 32'hffff_ffff, resp);
        compare_word(`RESP_SLVERR, resp);
        compare_word(led_val, data_t'(leds_o));
        read_reg(reg_addr(4'h3, 8'h00), rd, resp);
        compare_word(`RESP_SLVERR, resp);
        compare_word(32'h0, rd);

        test_name = "timer0";
        run_timer(0);
        test_name = "timer1";
        run_timer(1);

        test_name = "back_pressure";
        bp_val = data_t'(led_t'($random(seed)));
        @(posedge clk);
        #10;
        awvalid = 1'b1;
        awaddr  = reg_addr(`REGION_GPIO, `GPIO_LED_OFF);
        wvalid  = 1'b1;
        wdata   = bp_val;
        @(negedge clk);
        while (!(awready_o && wready_o)) @(negedge clk);
        @(posedge clk);
        #10;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b1;
        araddr  = reg_addr(`REGION_GPIO, `GPIO_LED_OFF);
        repeat (6) begin
            @(negedge clk);
            compare_word(32'h1, data_t'(bvalid_o));
            compare_word(`RESP_OKAY, bresp_o);
            compare_word(32'h0, data_t'(arready_o));
        end
        @(posedge clk);
        #10;
        bready = 1'b1;
        @(negedge clk);
        while (!arready_o) @(negedge clk);
        @(posedge clk);
        #10;
        bready  = 1'b0;
        arvalid = 1'b0;
        // Read response stalled for two cycles
        repeat (2) @(posedge clk);
        #10;
        rready = 1'b1;
        @(negedge clk);
        while (!rvalid_o) @(negedge clk);
        compare_word(bp_val, rdata_o);
        @(posedge clk);
        #10;
        rready = 1'b0;

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/periph_pkg.sv
hdl/axi_lite_reg_bridge.sv
hdl/irq_ctrl.sv
hdl/cmp_timer.sv
hdl/gpio_regs.sv
hdl/periph_top.sv
tb/tb_clk_gen.sv
tb/tb_periph_top.sv

// ==== Bender.yml ====
package:
  name: periph_subsys

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/periph_pkg.sv
      - hdl/axi_lite_reg_bridge.sv
      - hdl/irq_ctrl.sv
      - hdl/cmp_timer.sv
      - hdl/gpio_regs.sv
      - hdl/periph_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_periph_top.sv
